// File: bench/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    localparam int reset_cycles   = 10;
    localparam int program_words  = 24;
    localparam int pipe_slack     = 12;  // Fill, branch bubbles, margin
    localparam int stall_windows  = 3;
    localparam int max_stall      = 8;
    localparam int max_gap        = 8;
    localparam int drain_cycles   = 40;
    localparam int timeout_cycles = 3 * (reset_cycles + program_words + pipe_slack
                                    + stall_windows * (max_stall + max_gap) + drain_cycles);
    localparam int n_stores       = 8;

    localparam logic [31:0] load_addr   = 32'h44;
    localparam logic [31:0] marker_addr = 32'h80;

    // Immediates as encoded in program.hex
    localparam logic [19:0] lui_imm  = 20'h12345;
    localparam logic [11:0] addi_a   = 12'h5a5;
    localparam logic [11:0] addi_b   = 12'hff0;  // -16
    localparam logic [11:0] load_inc = 12'h123;

    localparam int t_reset  = 0;
    localparam int t_alu    = 1;
    localparam int t_load   = 2;
    localparam int t_branch = 3;
    localparam int t_order  = 4;
    localparam int t_stall  = 5;
    localparam int n_tests  = 6;

    logic                     clock      = 1'b0;
    logic                     arst_n     = 1'b0;
    logic                     enable     = 1'b1;
    logic [cpu_pkg::xlen-1:0] dmem_rdata = '0;
    cpu_pkg::dmem_req_t       dmem_req;

    cpu_pkg::dmem_req_t seen_req = '0;  // Request sampled mid-cycle
    logic [31:0]        data_mem [64];
    logic [31:0]        exp_addr [n_stores];
    logic [31:0]        exp_data [n_stores];
    int                 win_start [stall_windows];
    int                 win_len [stall_windows];
    int                 checks [n_tests];
    int                 failures [n_tests];
    int                 store_count = 0;
    int                 read_count  = 0;
    int                 cycle_count = 0;
    int                 run_cycle   = 0;
    logic               running     = 1'b0;

    cpu dut (
        .clock      (clock),
        .arst_n     (arst_n),
        .enable     (enable),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        forever #2 clock = ~clock;
    end

    function automatic string test_name(input int t);
        case (t)
            t_reset:  return "reset";
            t_alu:    return "alu";
            t_load:   return "load";
            t_branch: return "branch";
            t_order:  return "order";
            default:  return "stall";
        endcase
    endfunction

    function automatic logic stalled(input int c);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < stall_windows; k++) begin
            if (c >= win_start[k] && c < win_start[k] + win_len[k]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic note_failure(input int t, input string msg);
        failures[t]++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic report_test(input int t);
        $display("test %s: %0d checks, %0d failed", test_name(t), checks[t], failures[t]);
    endtask

    task automatic pick_stall_windows();
        int next;
        next = 0;
        for (int k = 0; k < stall_windows; k++) begin
            win_start[k] = next + 1 + int'($urandom % max_gap);
            win_len[k]   = 1 + int'($urandom % max_stall);  // 1 to 8 cycles
            next         = win_start[k] + win_len[k];
        end
    endtask

    // RV32I results of the program, in store order
    task automatic build_expected_stores();
        logic [31:0] x1, x2, x3, x4, x5, x6, x7, x8, x9, x11;
        x1  = {lui_imm, 12'h000};
        x2  = {{20{addi_a[11]}}, addi_a};
        x3  = {{20{addi_b[11]}}, addi_b};
        x4  = x1 + x2;
        x5  = x2 - x3;
        x6  = x2 & x3;
        x7  = x2 | x3;
        x8  = x1 ^ x3;
        x9  = ($signed(x3) < $signed(x2)) ? 32'd1 : 32'd0;
        x11 = x4 + {{20{load_inc[11]}}, load_inc};  // Reloaded x4 plus immediate
        exp_addr = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h50, 32'h60, 32'h54, 32'h58};
        exp_data = '{x1, x4, x5, x6, x7, x11, x8, x9};
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < 64; i++) begin
            data_mem[i] = 32'h5a000000 ^ (32'(i) * 32'h00030507);
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        int t;
        t = (store_count == 5) ? t_load : (store_count == 6) ? t_branch : t_alu;
        checks[t_branch]++;
        assert (addr != marker_addr)
            else note_failure(t_branch, $sformatf("store to skipped marker address %h", addr));
        checks[t_order]++;
        assert (store_count < n_stores)
            else note_failure(t_order, $sformatf("unexpected store of %h to %h", data, addr));
        if (store_count < n_stores) begin
            checks[t] += 2;
            assert (addr == exp_addr[store_count])
                else note_failure(t, $sformatf("store %0d address %h, expected %h",
                                  store_count, addr, exp_addr[store_count]));
            assert (data == exp_data[store_count])
                else note_failure(t, $sformatf("store %0d data %h, expected %h",
                                  store_count, data, exp_data[store_count]));
        end
        store_count++;
    endtask

    task automatic check_load(input logic [31:0] addr);
        checks[t_load] += 2;
        assert (read_count == 0)
            else note_failure(t_load, $sformatf("unexpected extra load from %h", addr));
        assert (addr == load_addr)
            else note_failure(t_load, $sformatf("load address %h, expected %h", addr, load_addr));
        read_count++;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clock) begin
        seen_req = dmem_req;
        if (!arst_n) begin
            checks[t_reset]++;
            assert (!dmem_req.read && !dmem_req.write)
                else note_failure(t_reset, "data memory strobe while in reset");
        end else begin
            if (!enable) begin
                checks[t_stall]++;
                assert (!dmem_req.read && !dmem_req.write)
                    else note_failure(t_stall, "data memory strobe while stalled");
            end
            if (dmem_req.write) begin
                check_store(dmem_req.addr, dmem_req.wdata);
            end
            if (dmem_req.read) begin
                check_load(dmem_req.addr);
            end
        end
    end

    // Data memory acts on the request of the cycle just ended
    always @(posedge clock) begin
        #1;
        if (seen_req.write) begin
            data_mem[seen_req.addr[7:2]] = seen_req.wdata;
        end
        if (seen_req.read) begin
            dmem_rdata = data_mem[seen_req.addr[7:2]];  // Held until next read
        end
    end

    always @(posedge clock) begin
        running = arst_n;
        #1;
        if (running) begin
            enable = !stalled(run_cycle);
            run_cycle++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycle_count, store_count, n_stores);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int total_checks;
        int total_failures;
        void'($urandom(29025));
        total_checks   = 0;
        total_failures = 0;
        for (int t = 0; t < n_tests; t++) begin
            checks[t]   = 0;
            failures[t] = 0;
        end
        pick_stall_windows();
        build_expected_stores();
        fill_data_memory();

        repeat (reset_cycles) @(posedge clock);
        #1;
        arst_n = 1'b1;
        report_test(t_reset);

        while (store_count < n_stores) begin
            @(posedge clock);
        end
        report_test(t_alu);
        report_test(t_load);

        // Self-loop must stay quiet
        repeat (drain_cycles) @(posedge clock);
        checks[t_order] += 2;
        assert (store_count == n_stores)
            else note_failure(t_order, $sformatf("%0d stores seen, expected %0d",
                              store_count, n_stores));
        assert (read_count == 1)
            else note_failure(t_order, $sformatf("%0d loads seen, expected 1", read_count));
        report_test(t_branch);
        report_test(t_order);
        report_test(t_stall);

        for (int t = 0; t < n_tests; t++) begin
            total_checks   += checks[t];
            total_failures += failures[t];
        end
        $display("Totals: %0d checks, %0d failed", total_checks, total_failures);
        if (total_failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/program.hex
// One 32-bit instruction word per line, word address 0 first
// Trailing comments give the assembly
123450B7  // lui  x1, 0x12345
5A500113  // addi x2, x0, 0x5a5
FF000193  // addi x3, x0, -16
04102023  // sw   x1, 0x40(x0)
00208233  // add  x4, x1, x2
403102B3  // sub  x5, x2, x3
00317333  // and  x6, x2, x3
04402223  // sw   x4, 0x44(x0)
04402503  // lw   x10, 0x44(x0)
003163B3  // or   x7, x2, x3
04502423  // sw   x5, 0x48(x0)
04602623  // sw   x6, 0x4c(x0)
12350593  // addi x11, x10, 0x123
0030C433  // xor  x8, x1, x3
0021A4B3  // slt  x9, x3, x2
04702823  // sw   x7, 0x50(x0)
06B02023  // sw   x11, 0x60(x0)
00450663  // beq  x10, x4, +12
08302023  // sw   x3, 0x80(x0)  marker, skipped
08302023  // sw   x3, 0x80(x0)  marker, skipped
00451463  // bne  x10, x4, +8    not taken
04802A23  // sw   x8, 0x54(x0)
04902C23  // sw   x9, 0x58(x0)
00000063  // beq  x0, x0, 0     self-loop

// File: logic/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     enable,     // Global stall when low
    output cpu_pkg::dmem_req_t       dmem_req,
    input  logic [cpu_pkg::xlen-1:0] dmem_rdata
);

    cpu_pkg::fetch_to_decode_t   if_de;
    cpu_pkg::decode_to_execute_t de_ex;
    cpu_pkg::execute_to_memory_t ex_mem;
    cpu_pkg::redirect_t          redirect;   // Back to fetch and decode
    cpu_pkg::reg_write_t         rb_write;

    logic [cpu_pkg::reg_addr_w-1:0] rs1_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_addr;
    logic [cpu_pkg::xlen-1:0]       rs1_value;
    logic [cpu_pkg::xlen-1:0]       rs2_value;

    fetch u_fetch (
        .clock     (clock),
        .arst_n    (arst_n),
        .enable    (enable),
        .redirect  (redirect),
        .to_decode (if_de)
    );

    decode u_decode (
        .clock      (clock),
        .arst_n     (arst_n),
        .enable     (enable),
        .from_fetch (if_de),
        .redirect   (redirect),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .to_execute (de_ex)
    );

    register_bank u_register_bank (
        .clock     (clock),
        .arst_n    (arst_n),
        .write     (rb_write),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    execute u_execute (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .from_decode (de_ex),
        .redirect    (redirect),
        .to_memory   (ex_mem)
    );

    memory_writeback u_memory_writeback (
        .clock        (clock),
        .arst_n       (arst_n),
        .enable       (enable),
        .from_execute (ex_mem),
        .dmem_req     (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .reg_write    (rb_write)
    );

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

    // Datapath sizes
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_words  = 64;
    localparam int imem_addr_w = $clog2(imem_words);  // ROM word index width

    localparam logic [xlen-1:0] reset_pc = '0;

    // RV32I major opcodes handled by the core
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,     // Signed compare
        alu_pass_b   // LUI
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_to_decode_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic                  use_imm;    // Operand b from immediate
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs1_value;
        logic [xlen-1:0]       rs2_value;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch;
        logic                  branch_ne;  // BNE when set, BEQ otherwise
    } decode_to_execute_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       result;     // ALU result or memory address
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } execute_to_memory_t;

    typedef struct packed {
        logic            read;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                  enable;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } reg_write_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

// File: logic/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                enable,
    input  cpu_pkg::fetch_to_decode_t           from_fetch,
    input  cpu_pkg::redirect_t                  redirect,
    output logic [cpu_pkg::reg_addr_w-1:0]      rs1_addr,
    output logic [cpu_pkg::reg_addr_w-1:0]      rs2_addr,
    input  logic [cpu_pkg::xlen-1:0]            rs1_value,
    input  logic [cpu_pkg::xlen-1:0]            rs2_value,
    output cpu_pkg::decode_to_execute_t         to_execute
);

    logic [cpu_pkg::xlen-1:0]    instr;
    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic                        funct7_b5;
    logic [cpu_pkg::xlen-1:0]    imm_i;
    logic [cpu_pkg::xlen-1:0]    imm_s;
    logic [cpu_pkg::xlen-1:0]    imm_b;
    logic [cpu_pkg::xlen-1:0]    imm_u;
    cpu_pkg::decode_to_execute_t decoded;
    cpu_pkg::decode_to_execute_t stage_q;
    logic                        valid_q;

    assign instr     = from_fetch.instr;
    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];  // SUB vs ADD

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // Register bank read ports
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        decoded           = '0;
        decoded.valid     = from_fetch.valid && !redirect.taken;
        decoded.pc        = from_fetch.pc;
        decoded.rs1_value = rs1_value;
        decoded.rs2_value = rs2_value;
        decoded.rd        = instr[11:7];
        decoded.alu_op    = cpu_pkg::alu_add;

        case (opcode)
            cpu_pkg::opcode_op: begin
                decoded.reg_write = 1'b1;
                case (funct3)
                    3'b000:  decoded.alu_op = funct7_b5 ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b111:  decoded.alu_op = cpu_pkg::alu_and;
                    3'b110:  decoded.alu_op = cpu_pkg::alu_or;
                    3'b100:  decoded.alu_op = cpu_pkg::alu_xor;
                    3'b010:  decoded.alu_op = cpu_pkg::alu_slt;
                    default: decoded.reg_write = 1'b0;  // Unsupported R-type
                endcase
            end
            cpu_pkg::opcode_op_imm: begin
                decoded.use_imm   = 1'b1;
                decoded.imm       = imm_i;
                decoded.reg_write = (funct3 == 3'b000);  // ADDI only
            end
            cpu_pkg::opcode_lui: begin
                decoded.alu_op    = cpu_pkg::alu_pass_b;
                decoded.use_imm   = 1'b1;
                decoded.imm       = imm_u;
                decoded.reg_write = 1'b1;
            end
            cpu_pkg::opcode_load: begin
                decoded.use_imm   = 1'b1;
                decoded.imm       = imm_i;
                decoded.reg_write = (funct3 == 3'b010);  // LW
                decoded.mem_read  = (funct3 == 3'b010);
            end
            cpu_pkg::opcode_store: begin
                decoded.use_imm   = 1'b1;
                decoded.imm       = imm_s;
                decoded.mem_write = (funct3 == 3'b010);  // SW
            end
            cpu_pkg::opcode_branch: begin
                decoded.imm       = imm_b;
                decoded.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                decoded.branch_ne = funct3[0];
            end
            default: ;  // Anything else is a no-op
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (enable) begin
            valid_q <= decoded.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            stage_q <= decoded;
        end
    end

    always_comb begin
        to_execute       = stage_q;
        to_execute.valid = valid_q;
    end

endmodule

// File: logic/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        enable,
    input  cpu_pkg::decode_to_execute_t from_decode,
    output cpu_pkg::redirect_t          redirect,
    output cpu_pkg::execute_to_memory_t to_memory
);

    logic [cpu_pkg::xlen-1:0]    operand_a;
    logic [cpu_pkg::xlen-1:0]    operand_b;
    logic [cpu_pkg::xlen-1:0]    alu_result;
    logic                        equal;
    cpu_pkg::execute_to_memory_t stage_q;
    logic                        valid_q;

    assign operand_a = from_decode.rs1_value;
    assign operand_b = from_decode.use_imm ? from_decode.imm : from_decode.rs2_value;

    always_comb begin
        case (from_decode.alu_op)
            cpu_pkg::alu_add:    alu_result = operand_a + operand_b;
            cpu_pkg::alu_sub:    alu_result = operand_a - operand_b;
            cpu_pkg::alu_and:    alu_result = operand_a & operand_b;
            cpu_pkg::alu_or:     alu_result = operand_a | operand_b;
            cpu_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
            cpu_pkg::alu_slt:    alu_result = {{(cpu_pkg::xlen-1){1'b0}},
                                               $signed(operand_a) < $signed(operand_b)};
            cpu_pkg::alu_pass_b: alu_result = operand_b;
            default:             alu_result = operand_a + operand_b;
        endcase
    end

    // Branch compare always on both registers
    assign equal = (from_decode.rs1_value == from_decode.rs2_value);

    assign redirect.taken  = from_decode.valid && from_decode.branch
                             && (from_decode.branch_ne ? !equal : equal);
    assign redirect.target = from_decode.pc + from_decode.imm;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (enable) begin
            valid_q <= from_decode.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            stage_q.result     <= alu_result;
            stage_q.store_data <= from_decode.rs2_value;  // SW data
            stage_q.rd         <= from_decode.rd;
            stage_q.reg_write  <= from_decode.reg_write;
            stage_q.mem_read   <= from_decode.mem_read;
            stage_q.mem_write  <= from_decode.mem_write;
            stage_q.valid      <= from_decode.valid;
        end
    end

    always_comb begin
        to_memory       = stage_q;
        to_memory.valid = valid_q;
    end

endmodule

// File: logic/fetch.sv
`timescale 1ns/1ns

module fetch (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      enable,
    input  cpu_pkg::redirect_t        redirect,
    output cpu_pkg::fetch_to_decode_t to_decode
);

    logic [cpu_pkg::xlen-1:0] rom [cpu_pkg::imem_words];
    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] pc_q;
    logic [cpu_pkg::xlen-1:0] instr_q;
    logic                     valid_q;

    // Program image
    initial begin
        $readmemh("bench/program.hex", rom);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= cpu_pkg::reset_pc;
            valid_q <= 1'b0;
        end else if (enable) begin
            if (redirect.taken) begin
                pc      <= redirect.target;
                valid_q <= 1'b0;  // Wrong-path slot becomes a bubble
            end else begin
                pc      <= pc + 32'd4;
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            pc_q    <= pc;
            instr_q <= rom[pc[cpu_pkg::imem_addr_w+1:2]];  // Word addressed
        end
    end

    assign to_decode = '{valid: valid_q, pc: pc_q, instr: instr_q};

endmodule

// File: logic/memory_writeback.sv
`timescale 1ns/1ns

module memory_writeback (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        enable,
    input  cpu_pkg::execute_to_memory_t from_execute,
    output cpu_pkg::dmem_req_t          dmem_req,
    input  logic [cpu_pkg::xlen-1:0]    dmem_rdata,
    output cpu_pkg::reg_write_t         reg_write
);

    logic                           wb_write;   // Pending register write
    logic                           wb_load;
    logic [cpu_pkg::reg_addr_w-1:0] wb_rd;
    logic [cpu_pkg::xlen-1:0]       wb_result;

    // Strobes last one enabled cycle
    assign dmem_req.read  = from_execute.valid && from_execute.mem_read && enable;
    assign dmem_req.write = from_execute.valid && from_execute.mem_write && enable;
    assign dmem_req.addr  = from_execute.result;
    assign dmem_req.wdata = from_execute.store_data;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_write <= 1'b0;
        end else if (enable) begin
            wb_write <= from_execute.valid && from_execute.reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            wb_rd     <= from_execute.rd;
            wb_result <= from_execute.result;
            wb_load   <= from_execute.mem_read;
        end
    end

    // Write lands at the next enabled edge
    assign reg_write.enable = wb_write && enable;
    assign reg_write.addr   = wb_rd;
    assign reg_write.data   = wb_load ? dmem_rdata : wb_result;  // Load data held by memory

endmodule

// File: logic/register_bank.sv
`timescale 1ns/1ns

module register_bank (
    input  logic                           clock,
    input  logic                           arst_n,
    input  cpu_pkg::reg_write_t            write,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [cpu_pkg::xlen-1:0]       rs1_value,
    output logic [cpu_pkg::xlen-1:0]       rs2_value
);

    logic [cpu_pkg::xlen-1:0] regs [2**cpu_pkg::reg_addr_w];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && write.addr != '0) begin
            regs[write.addr] <= write.data;  // x0 never written
        end
    end

    // Reads see a write landing at the same edge
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_value = '0;
        end else if (write.enable && write.addr == rs1_addr) begin
            rs1_value = write.data;
        end else begin
            rs1_value = regs[rs1_addr];
        end

        if (rs2_addr == '0) begin
            rs2_value = '0;
        end else if (write.enable && write.addr == rs2_addr) begin
            rs2_value = write.data;
        end else begin
            rs2_value = regs[rs2_addr];
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the cpu testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation run failed with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1

// File: sources.f
logic/cpu_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/register_bank.sv
logic/execute.sv
logic/memory_writeback.sv
logic/cpu.sv
bench/cpu_tb.sv
